/* include/fpr_perr_defines.svh */
// FPR parity recovery constants
`ifndef FPR_PERR_DEFINES_SVH
`define FPR_PERR_DEFINES_SVH

// Register file geometry
`define FPR_ADDR_W 6
`define FPR_THREADS 2

// A dummy needs this many cycles to go from rf0 to ex7
`define PERR_DUMMY_STAGES 8

// Cycles between ex3 detection and the start of the sequence
`define PERR_SETTLE 4

// One-hot recovery states, bit 0 is idle
`define PERR_ST_IDLE 3'b100
`define PERR_ST_READOUT 3'b010
`define PERR_ST_WRITEBACK 3'b001

`endif

/* hw/fpr_perr_pkg.sv */
// FPR parity recovery types
`default_nettype none

`include "fpr_perr_defines.svh"

package fpr_perr_pkg;

   // Floating-point register address
   typedef logic [0:`FPR_ADDR_W-1] fpr_addr_t;

   // One bit per thread, thread 0 in bit 0
   typedef logic [0:`FPR_THREADS-1] tid_mask_t;

   // ----------------------------------------
   // Recovery sequencer state
   // ----------------------------------------
   // Readout reads both copies, writeback moves the good copy onto the bad one
   typedef enum logic [0:2]
   {
      PERR_IDLE      = `PERR_ST_IDLE,
      PERR_READOUT   = `PERR_ST_READOUT,
      PERR_WRITEBACK = `PERR_ST_WRITEBACK
   } perr_state_t;

endpackage

`default_nettype wire

/* hw/fpr_perr_if.sv */
// FPR parity recovery interfaces
`default_nettype none

// ----------------------------------------
// Detector to sequencer
// ----------------------------------------
interface perr_event_if;
   logic                    err_any;
   logic                    capture;
   fpr_perr_pkg::fpr_addr_t cap_addr;
   fpr_perr_pkg::tid_mask_t cap_tid;
   logic                    b_bad;
   logic                    c_bad;
   // Sequencer allows a new capture only while this is high
   logic                    arm;

   modport detect (
      output err_any, capture, cap_addr, cap_tid, b_bad, c_bad,
      input  arm
   );

   modport seq (
      input  err_any, capture, cap_addr, cap_tid, b_bad, c_bad,
      output arm
   );
endinterface

// ----------------------------------------
// Sequencer to rf0 read-port arbiter
// ----------------------------------------
interface rf_port_if;
   logic                    rec_v;
   fpr_perr_pkg::fpr_addr_t rec_addr;
   fpr_perr_pkg::tid_mask_t rec_tid;
   logic                    writeback;
   logic                    force_c;

   modport recovery (
      output rec_v, rec_addr, rec_tid, writeback, force_c
   );

   modport arb (
      input  rec_v, rec_addr, rec_tid, writeback, force_c
   );
endinterface

`default_nettype wire

/* hw/perr_detect.sv */
// FPR parity error detector
`default_nettype none

`include "fpr_perr_defines.svh"

module perr_detect (
   input  logic                    nclk,
   input  logic                    rst_n,
   input  fpr_perr_pkg::fpr_addr_t ex1_fra,
   input  fpr_perr_pkg::fpr_addr_t ex1_frb,
   input  fpr_perr_pkg::fpr_addr_t ex1_frc,
   input  fpr_perr_pkg::fpr_addr_t ex1_frs,
   input  logic                    a_check,
   input  logic                    b_check,
   input  logic                    c_check,
   input  logic                    s_check,
   input  logic                    fra_v,
   input  logic                    frb_v,
   input  logic                    frc_v,
   input  logic                    str_v,
   input  logic                    frs_byp,
   input  logic                    msr_fp_act,
   input  fpr_perr_pkg::tid_mask_t instr_v,
   input  fpr_perr_pkg::tid_mask_t flush,
   output logic                    sto_parity_err,
   perr_event_if.detect            evt
);

   // Operand slots are A, B, C and S in that order
   fpr_perr_pkg::fpr_addr_t [0:3] ex2_addr_q;
   fpr_perr_pkg::fpr_addr_t [0:3] ex3_addr_q;

   logic                    a_err;
   logic                    b_err;
   logic                    c_err;
   logic                    s_err;
   fpr_perr_pkg::tid_mask_t sto_err;
   fpr_perr_pkg::tid_mask_t abc_err;
   fpr_perr_pkg::tid_mask_t fpr_err;

   // ----------------------------------------
   // Address staging ex1 to ex3
   // ----------------------------------------
   always_ff @(posedge nclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ex2_addr_q <= '0;
         ex3_addr_q <= '0;
      end
      else
      begin
         ex2_addr_q <= {ex1_fra, ex1_frb, ex1_frc, ex1_frs};
         ex3_addr_q <= ex2_addr_q;
      end
   end

   // ----------------------------------------
   // ex3 parity qualification
   // ----------------------------------------
   assign a_err = a_check & fra_v;
   assign b_err = b_check & frb_v;
   assign c_err = c_check & frc_v;

   // A bypassed store operand never came out of the register file
   assign s_err = s_check & str_v & ~frs_byp;

   assign sto_err = {`FPR_THREADS{s_err}} & instr_v;
   assign abc_err = {`FPR_THREADS{a_err | b_err | c_err}} & instr_v;
   assign fpr_err = (sto_err | abc_err) & ~flush & {`FPR_THREADS{msr_fp_act}};

   assign sto_parity_err = |sto_err;

   assign evt.err_any = |fpr_err;
   assign evt.capture = evt.err_any & evt.arm;
   assign evt.cap_tid = fpr_err;

   // Readout compares both copies, so the raw checks go straight on
   assign evt.b_bad = b_check;
   assign evt.c_bad = c_check;

   // First erring operand wins, store operand last
   always_comb
   begin
      if (a_err)
         evt.cap_addr = ex3_addr_q[0];
      else if (b_err)
         evt.cap_addr = ex3_addr_q[1];
      else if (c_err)
         evt.cap_addr = ex3_addr_q[2];
      else
         evt.cap_addr = ex3_addr_q[3];
   end

endmodule

`default_nettype wire

/* hw/perr_recovery_seq.sv */
// FPR parity recovery sequencer
`default_nettype none

`include "fpr_perr_defines.svh"

module perr_recovery_seq (
   input  logic                    nclk,
   input  logic                    rst_n,
   input  logic                    hang_trigger,
   perr_event_if.seq               evt,
   rf_port_if.recovery             port,
   output logic                    hold_all,
   output logic                    sm_running,
   output logic                    fix_perr_ex7,
   output fpr_perr_pkg::tid_mask_t err_ce,
   output fpr_perr_pkg::tid_mask_t err_ue
);

   // Positions in the dummy pipe, rf0 is slot 0
   localparam int DUMMY_EX3 = 4;
   localparam int DUMMY_EX7 = `PERR_DUMMY_STAGES;

   fpr_perr_pkg::perr_state_t state_q;
   fpr_perr_pkg::perr_state_t state_d;

   logic [0:`PERR_SETTLE-1]       settle_q;
   logic [0:`PERR_DUMMY_STAGES]   dummy_q;
   fpr_perr_pkg::fpr_addr_t       cap_addr_q;
   fpr_perr_pkg::tid_mask_t       cap_tid_q;
   logic                          move_f0_to_f1_q;
   logic                          move_f1_to_f0_q;
   logic                          ce_q;
   logic                          ue_q;
   logic                          hold_q;

   logic st_idle;
   logic st_readout;
   logic st_writeback;
   logic seq_beg;
   logic ns_idle;
   logic ns_readout;
   logic ns_writeback;
   logic new_dummy;
   logic readout_ex3;
   logic wb_rf0;
   logic rf0_ce;
   logic rf0_ue;

   assign st_idle      = (state_q == fpr_perr_pkg::PERR_IDLE);
   assign st_readout   = (state_q == fpr_perr_pkg::PERR_READOUT);
   assign st_writeback = (state_q == fpr_perr_pkg::PERR_WRITEBACK);

   // Last slot of the settle window starts the sequence
   assign seq_beg = settle_q[`PERR_SETTLE-1];

   // No new capture until the previous one has cleared the window
   assign evt.arm = st_idle & ~(|settle_q);

   // ----------------------------------------
   // Next state
   // ----------------------------------------
   // Back to idle after writeback reaches ex7, or right after a UE
   assign ns_idle      = st_writeback & (rf0_ue | dummy_q[DUMMY_EX7]);
   assign ns_readout   = st_idle & seq_beg;
   assign ns_writeback = st_readout & dummy_q[DUMMY_EX7];
   assign new_dummy    = ns_readout | ns_writeback;

   always_comb
   begin
      state_d = state_q;
      if (ns_idle)
         state_d = fpr_perr_pkg::PERR_IDLE;
      else if (ns_readout)
         state_d = fpr_perr_pkg::PERR_READOUT;
      else if (ns_writeback)
         state_d = fpr_perr_pkg::PERR_WRITEBACK;
   end

   // Both copies read back bad means f0 and f1 each need the other
   assign readout_ex3 = st_readout & dummy_q[DUMMY_EX3];
   assign wb_rf0      = st_writeback & dummy_q[0];
   assign rf0_ue      = wb_rf0 & move_f0_to_f1_q & move_f1_to_f0_q;
   assign rf0_ce      = wb_rf0 & ~(move_f0_to_f1_q & move_f1_to_f0_q);

   always_ff @(posedge nclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q         <= fpr_perr_pkg::PERR_IDLE;
         settle_q        <= '0;
         dummy_q         <= '0;
         cap_tid_q       <= '0;
         move_f0_to_f1_q <= 1'b0;
         move_f1_to_f0_q <= 1'b0;
         ce_q            <= 1'b0;
         ue_q            <= 1'b0;
         hold_q          <= 1'b0;
      end
      else
      begin
         state_q  <= state_d;
         settle_q <= {evt.capture, settle_q[0:`PERR_SETTLE-2]};
         dummy_q  <= {new_dummy, dummy_q[0:`PERR_DUMMY_STAGES-1]};
         if (evt.capture)
            cap_tid_q <= evt.cap_tid;
         // B reads f1 and C reads f0 during readout
         if (readout_ex3)
         begin
            move_f0_to_f1_q <= evt.b_bad;
            move_f1_to_f0_q <= evt.c_bad;
         end
         ce_q   <= rf0_ce;
         ue_q   <= rf0_ue;
         hold_q <= hang_trigger | evt.err_any | (|settle_q) | ~st_idle;
      end
   end

   always_ff @(posedge nclk)
   begin
      if (evt.capture)
         cap_addr_q <= evt.cap_addr;
   end

   // ----------------------------------------
   // Outputs
   // ----------------------------------------
   assign port.rec_v     = dummy_q[0];
   assign port.rec_addr  = cap_addr_q;
   assign port.rec_tid   = cap_tid_q;
   assign port.writeback = st_writeback;
   // Only f0 moving onto f1 needs the C copy forced
   assign port.force_c   = st_writeback & move_f0_to_f1_q & ~move_f1_to_f0_q;

   assign hold_all     = hold_q;
   assign sm_running   = ~st_idle;
   assign fix_perr_ex7 = dummy_q[DUMMY_EX7];

   assign err_ce = cap_tid_q & {`FPR_THREADS{ce_q}};
   assign err_ue = cap_tid_q & {`FPR_THREADS{ue_q}};

endmodule

`default_nettype wire

/* hw/rf_read_arb.sv */
// FPR rf0 read-port arbiter
`default_nettype none

module rf_read_arb (
   input  logic                    nclk,
   input  logic                    rst_n,
   input  fpr_perr_pkg::fpr_addr_t issue_frb,
   input  fpr_perr_pkg::fpr_addr_t issue_frc,
   input  fpr_perr_pkg::tid_mask_t issue_tid,
   rf_port_if.arb                  port,
   output fpr_perr_pkg::fpr_addr_t dcd_frb,
   output fpr_perr_pkg::fpr_addr_t dcd_frc,
   output fpr_perr_pkg::tid_mask_t dcd_tid,
   output logic                    fsel_ovrd,
   output logic                    force_c_ex2
);

   // Bits are grant, writeback and force C
   logic [0:2] ex1_q;
   logic [0:2] ex2_q;

   // ----------------------------------------
   // rf0 mux, recovery always wins
   // ----------------------------------------
   // Same address on B and C so both copies come out together
   assign dcd_frb = port.rec_v ? port.rec_addr : issue_frb;
   assign dcd_frc = port.rec_v ? port.rec_addr : issue_frc;
   assign dcd_tid = port.rec_v ? port.rec_tid : issue_tid;

   always_ff @(posedge nclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ex1_q <= '0;
         ex2_q <= '0;
      end
      else
      begin
         ex1_q <= {port.rec_v, port.writeback, port.force_c};
         ex2_q <= ex1_q;
      end
   end

   // Data select override is only for a writeback dummy
   assign fsel_ovrd   = ex2_q[0] & ex2_q[1];
   assign force_c_ex2 = ex2_q[0] & ex2_q[2];

endmodule

`default_nettype wire

/* hw/fpr_perr_recovery.sv */
// FPR parity recovery top
`default_nettype none

module fpr_perr_recovery (
   input  logic                    nclk,
   input  logic                    rst_n,
   input  logic                    hang_trigger,
   input  fpr_perr_pkg::fpr_addr_t ex1_fra,
   input  fpr_perr_pkg::fpr_addr_t ex1_frb,
   input  fpr_perr_pkg::fpr_addr_t ex1_frc,
   input  fpr_perr_pkg::fpr_addr_t ex1_frs,
   input  logic                    a_check,
   input  logic                    b_check,
   input  logic                    c_check,
   input  logic                    s_check,
   input  logic                    fra_v,
   input  logic                    frb_v,
   input  logic                    frc_v,
   input  logic                    str_v,
   input  logic                    frs_byp,
   input  logic                    msr_fp_act,
   input  fpr_perr_pkg::tid_mask_t instr_v,
   input  fpr_perr_pkg::tid_mask_t flush,
   input  fpr_perr_pkg::fpr_addr_t issue_frb,
   input  fpr_perr_pkg::fpr_addr_t issue_frc,
   input  fpr_perr_pkg::tid_mask_t issue_tid,
   output logic                    sto_parity_err,
   output logic                    hold_all,
   output logic                    sm_running,
   output logic                    fix_perr_ex7,
   output fpr_perr_pkg::tid_mask_t err_ce,
   output fpr_perr_pkg::tid_mask_t err_ue,
   output fpr_perr_pkg::fpr_addr_t dcd_frb,
   output fpr_perr_pkg::fpr_addr_t dcd_frc,
   output fpr_perr_pkg::tid_mask_t dcd_tid,
   output logic                    fsel_ovrd,
   output logic                    force_c_ex2
);

   perr_event_if evt ();
   rf_port_if    port ();

   perr_detect u_detect (
      .nclk           (nclk),
      .rst_n          (rst_n),
      .ex1_fra        (ex1_fra),
      .ex1_frb        (ex1_frb),
      .ex1_frc        (ex1_frc),
      .ex1_frs        (ex1_frs),
      .a_check        (a_check),
      .b_check        (b_check),
      .c_check        (c_check),
      .s_check        (s_check),
      .fra_v          (fra_v),
      .frb_v          (frb_v),
      .frc_v          (frc_v),
      .str_v          (str_v),
      .frs_byp        (frs_byp),
      .msr_fp_act     (msr_fp_act),
      .instr_v        (instr_v),
      .flush          (flush),
      .sto_parity_err (sto_parity_err),
      .evt            (evt)
   );

   perr_recovery_seq u_seq (
      .nclk         (nclk),
      .rst_n        (rst_n),
      .hang_trigger (hang_trigger),
      .evt          (evt),
      .port         (port),
      .hold_all     (hold_all),
      .sm_running   (sm_running),
      .fix_perr_ex7 (fix_perr_ex7),
      .err_ce       (err_ce),
      .err_ue       (err_ue)
   );

   rf_read_arb u_arb (
      .nclk        (nclk),
      .rst_n       (rst_n),
      .issue_frb   (issue_frb),
      .issue_frc   (issue_frc),
      .issue_tid   (issue_tid),
      .port        (port),
      .dcd_frb     (dcd_frb),
      .dcd_frc     (dcd_frc),
      .dcd_tid     (dcd_tid),
      .fsel_ovrd   (fsel_ovrd),
      .force_c_ex2 (force_c_ex2)
   );

endmodule

`default_nettype wire

/* testbench/fpr_perr_chk.sv */
// FPR parity recovery assertions
`default_nettype none

module fpr_perr_chk (
   input logic                    nclk,
   input logic                    rst_n,
   input logic                    hang_trigger,
   input fpr_perr_pkg::fpr_addr_t ex1_fra,
   input fpr_perr_pkg::fpr_addr_t ex1_frb,
   input fpr_perr_pkg::fpr_addr_t ex1_frc,
   input fpr_perr_pkg::fpr_addr_t ex1_frs,
   input logic                    a_check,
   input logic                    b_check,
   input logic                    c_check,
   input logic                    s_check,
   input logic                    fra_v,
   input logic                    frb_v,
   input logic                    frc_v,
   input logic                    str_v,
   input logic                    frs_byp,
   input logic                    msr_fp_act,
   input fpr_perr_pkg::tid_mask_t instr_v,
   input fpr_perr_pkg::tid_mask_t flush,
   input fpr_perr_pkg::fpr_addr_t issue_frb,
   input fpr_perr_pkg::fpr_addr_t issue_frc,
   input fpr_perr_pkg::tid_mask_t issue_tid,
   input logic                    sto_parity_err,
   input logic                    hold_all,
   input logic                    sm_running,
   input logic                    fix_perr_ex7,
   input fpr_perr_pkg::tid_mask_t err_ce,
   input fpr_perr_pkg::tid_mask_t err_ue,
   input fpr_perr_pkg::fpr_addr_t dcd_frb,
   input fpr_perr_pkg::fpr_addr_t dcd_frc,
   input fpr_perr_pkg::tid_mask_t dcd_tid,
   input logic                    fsel_ovrd,
   input logic                    force_c_ex2
);

   // Operand slots A, B, C and S
   fpr_perr_pkg::fpr_addr_t [0:3] ex2_addr;
   fpr_perr_pkg::fpr_addr_t [0:3] ex3_addr;
   fpr_perr_pkg::fpr_addr_t       exp_addr;
   fpr_perr_pkg::tid_mask_t       exp_tid;
   fpr_perr_pkg::tid_mask_t       thr_err;
   logic a_err, b_err, c_err, s_err, err_in;
   logic sto_exp;
   int   run_len;
   int   fails = 0;

   task automatic count_failure(input string msg);
      $error("%s", msg);
      fails++;
   endtask

   // ----------------------------------------
   // Expected capture
   // ----------------------------------------
   assign a_err   = a_check & fra_v;
   assign b_err   = b_check & frb_v;
   assign c_err   = c_check & frc_v;
   assign s_err   = s_check & str_v & ~frs_byp;
   assign thr_err = msr_fp_act ? (instr_v & ~flush) : '0;
   assign err_in  = (a_err | b_err | c_err | s_err) & (|thr_err);
   assign sto_exp = s_check & str_v & ~frs_byp & (|instr_v);

   always_ff @(posedge nclk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ex2_addr <= '0;
         ex3_addr <= '0;
         exp_addr <= '0;
         exp_tid  <= '0;
         run_len  <= 0;
      end
      else
      begin
         ex2_addr <= {ex1_fra, ex1_frb, ex1_frc, ex1_frs};
         ex3_addr <= ex2_addr;
         // With hold_all low the sequencer is armed
         if (err_in && !hold_all)
         begin
            exp_addr <= a_err ? ex3_addr[0] : b_err ? ex3_addr[1] :
                        c_err ? ex3_addr[2] : ex3_addr[3];
            exp_tid  <= thr_err;
         end
         run_len <= sm_running ? run_len + 1 : 0;
      end
   end

   // ----------------------------------------
   // Properties
   // ----------------------------------------
   a_pass: assert property (@(posedge nclk) disable iff (!rst_n)
      !sm_running |-> dcd_frb == issue_frb && dcd_frc == issue_frc && dcd_tid == issue_tid)
      else count_failure("Read port not passed through to issue while idle");
   a_ovrd: assert property (@(posedge nclk) disable iff (!rst_n)
      fsel_ovrd |-> $past(sm_running, 2))
      else count_failure("fsel_ovrd without a recovery dummy in flight");
   a_force: assert property (@(posedge nclk) disable iff (!rst_n) force_c_ex2 |-> fsel_ovrd)
      else count_failure("force_c_ex2 outside a writeback dummy");
   a_hold: assert property (@(posedge nclk) disable iff (!rst_n) err_in |=> hold_all)
      else count_failure("hold_all missing after a qualified error");
   a_hang: assert property (@(posedge nclk) disable iff (!rst_n) hang_trigger |=> hold_all)
      else count_failure("hold_all did not follow hang_trigger");
   a_quiet: assert property (@(posedge nclk) disable iff (!rst_n)
      !hold_all && !err_in && !hang_trigger |=> !hold_all)
      else count_failure("hold_all raised without a qualified error");
   a_run_hold: assert property (@(posedge nclk) disable iff (!rst_n) sm_running |-> hold_all)
      else count_failure("Sequence running while issue is not held");
   a_start: assert property (@(posedge nclk) disable iff (!rst_n)
      $past(err_in && !hold_all, 5) |-> sm_running)
      else count_failure("Readout did not start five cycles after capture");
   a_addr: assert property (@(posedge nclk) disable iff (!rst_n)
      $rose(sm_running) |-> dcd_frb == exp_addr && dcd_frc == exp_addr)
      else count_failure($sformatf("FAIL dcd_frb 0x%h dcd_frc 0x%h expected 0x%h",
         $sampled(dcd_frb), $sampled(dcd_frc), exp_addr));
   a_tid: assert property (@(posedge nclk) disable iff (!rst_n)
      $rose(sm_running) |-> dcd_tid == exp_tid)
      else count_failure($sformatf("FAIL dcd_tid 0x%h expected 0x%h",
         $sampled(dcd_tid), exp_tid));
   a_sto: assert property (@(posedge nclk) disable iff (!rst_n) sto_parity_err == sto_exp)
      else count_failure($sformatf("FAIL sto_parity_err 0x%h expected 0x%h",
         $sampled(sto_parity_err), $sampled(sto_exp)));
   a_ce: assert property (@(posedge nclk) disable iff (!rst_n)
      (|err_ce) |-> err_ce == exp_tid && err_ue == '0)
      else count_failure($sformatf("FAIL err_ce 0x%h expected 0x%h",
         $sampled(err_ce), exp_tid));
   a_ue: assert property (@(posedge nclk) disable iff (!rst_n)
      (|err_ue) |-> err_ue == exp_tid && err_ce == '0)
      else count_failure($sformatf("FAIL err_ue 0x%h expected 0x%h",
         $sampled(err_ue), exp_tid));
   a_pulse: assert property (@(posedge nclk) disable iff (!rst_n)
      (|err_ce) || (|err_ue) |=> err_ce == '0 && err_ue == '0)
      else count_failure("Report held for more than one cycle");
   a_len: assert property (@(posedge nclk) disable iff (!rst_n) run_len <= 30)
      else count_failure("Recovery sequence ran longer than 30 cycles");

   // Readout dummy enters rf0 as the sequence starts and reaches ex7 eight cycles later
   a_fix_ro: assert property (@(posedge nclk) disable iff (!rst_n)
      $rose(sm_running) |-> ##8 fix_perr_ex7)
      else count_failure("fix_perr_ex7 missing when the readout dummy reached ex7");
   a_fix_wb: assert property (@(posedge nclk) disable iff (!rst_n)
      fsel_ovrd |-> ##6 fix_perr_ex7)
      else count_failure("fix_perr_ex7 missing when the writeback dummy reached ex7");
   a_fix_src: assert property (@(posedge nclk) disable iff (!rst_n)
      fix_perr_ex7 |-> $past(sm_running, 8))
      else count_failure("fix_perr_ex7 raised without a dummy in ex7");

endmodule

bind fpr_perr_recovery fpr_perr_chk chk (.*);

`default_nettype wire

/* testbench/tb_fpr_perr_recovery.sv */
// FPR parity recovery testbench
`default_nettype none

module tb_fpr_perr_recovery;

   localparam int IDLE_LEN = 40;
   localparam int SEQ_LEN  = 45;
   localparam int SUP_LEN  = 20;
   localparam int LIMIT    = (4 + IDLE_LEN + 4 * SEQ_LEN + SUP_LEN) * 3 / 2;

   logic nclk, rst_n, hang_trigger;
   fpr_perr_pkg::fpr_addr_t ex1_fra, ex1_frb, ex1_frc, ex1_frs;
   logic a_check, b_check, c_check, s_check;
   logic fra_v, frb_v, frc_v, str_v, frs_byp, msr_fp_act;
   fpr_perr_pkg::tid_mask_t instr_v, flush, issue_tid, dcd_tid, err_ce, err_ue;
   fpr_perr_pkg::fpr_addr_t issue_frb, issue_frc, dcd_frb, dcd_frc;
   logic sto_parity_err, hold_all, sm_running, fix_perr_ex7, fsel_ovrd, force_c_ex2;

   logic [31:0] lfsr;
   int cycles = 0;
   int errors = 0;
   int tests = 0;
   int bad_tests = 0;
   int fails_before;
   int ce_seen, ue_seen, ovrd_seen, forced_seen, busy_seen;

   fpr_perr_recovery uut (.*);

   initial
   begin
      nclk = 1'b0;
      forever #2 nclk = ~nclk;
   end

   // Scoreboard counters and the run limit
   always @(posedge nclk)
   begin
      cycles++;
      if (cycles > LIMIT)
      begin
         $display("Run stopped after %0d cycles, a wait never ended", cycles);
         $display("Simulation failed");
         $finish;
      end
      else if (rst_n)
      begin
         ce_seen     += (|err_ce) ? 1 : 0;
         ue_seen     += (|err_ue) ? 1 : 0;
         ovrd_seen   += fsel_ovrd ? 1 : 0;
         forced_seen += (fsel_ovrd && force_c_ex2) ? 1 : 0;
         busy_seen   += (hold_all || sm_running) ? 1 : 0;
      end
   end

   // Galois form stepped once per bit
   function automatic logic [31:0] next_lfsr(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[30:0], lfsr[0]};
         lfsr = next_lfsr(lfsr);
      end
      return v;
   endfunction

   task automatic quiet_checks();
      {a_check, b_check, c_check, s_check} = '0;
      {fra_v, frb_v, frc_v, str_v, frs_byp} = '0;
      msr_fp_act = 1'b1;
      instr_v = '0;
      flush = '0;
   endtask

   task automatic drive_idle(input int n);
      for (int i = 0; i < n; i++)
      begin
         @(negedge nclk);
         issue_frb = fpr_perr_pkg::fpr_addr_t'(take_bits(6));
         issue_frc = fpr_perr_pkg::fpr_addr_t'(take_bits(6));
         issue_tid = fpr_perr_pkg::tid_mask_t'(take_bits(2));
         hang_trigger = (i == n / 2);
      end
   endtask

   // ----------------------------------------
   // Error injection and readout
   // ----------------------------------------
   // The check rises two cycles after its addresses enter ex1
   task automatic inject_error(input logic store, input logic fp_act, input logic flush_on);
      fpr_perr_pkg::tid_mask_t tid;
      logic [31:0] abc;
      tid = take_bits(1) ? 2'b10 : 2'b01;
      abc = take_bits(3);
      for (int i = 0; i < 3; i++)
      begin
         @(negedge nclk);
         ex1_fra = fpr_perr_pkg::fpr_addr_t'(take_bits(6));
         ex1_frb = fpr_perr_pkg::fpr_addr_t'(take_bits(6));
         ex1_frc = fpr_perr_pkg::fpr_addr_t'(take_bits(6));
         ex1_frs = fpr_perr_pkg::fpr_addr_t'(take_bits(6));
      end
      {fra_v, frb_v, frc_v} = store ? 3'b000 : 3'b111;
      {a_check, b_check, c_check} = store ? 3'b000 : ((abc[2:0] == 0) ? 3'b010 : abc[2:0]);
      {s_check, str_v} = {store, store};
      msr_fp_act = fp_act;
      instr_v = tid;
      flush = flush_on ? tid : '0;
      @(negedge nclk);
      quiet_checks();
   endtask

   task automatic readout_checks(input logic b, input logic c);
      while (!sm_running)
         @(negedge nclk);
      // The readout dummy reaches ex3 four cycles after rf0
      repeat (4) @(negedge nclk);
      b_check = b;
      c_check = c;
      @(negedge nclk);
      quiet_checks();
   endtask

   task automatic wait_done();
      do
         @(negedge nclk);
      while (sm_running || hold_all);
      repeat (3) @(negedge nclk);
   endtask

   task automatic expect_count(input string what, input int got, input int exp);
      if (got != exp)
      begin
         $display("FAIL %s got 0x%0h expected 0x%0h", what, got, exp);
         errors++;
      end
   endtask

   task automatic start_test();
      fails_before = errors + uut.chk.fails;
      {ce_seen, ue_seen, ovrd_seen, forced_seen, busy_seen} = '0;
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors + uut.chk.fails > fails_before)
      begin
         bad_tests++;
         $display("test %s: failed", name);
      end
      else
         $display("test %s: passed", name);
   endtask

   task automatic run_sequence(input string name, input logic store, input logic b,
                               input logic c, input int exp_ce, input int exp_ue);
      start_test();
      inject_error(store, 1'b1, 1'b0);
      readout_checks(b, c);
      wait_done();
      expect_count("err_ce pulses", ce_seen, exp_ce);
      expect_count("err_ue pulses", ue_seen, exp_ue);
      expect_count("fsel_ovrd cycles", ovrd_seen, 1);
      expect_count("force_c_ex2 with fsel_ovrd", forced_seen, (b && !c) ? 1 : 0);
      end_test(name);
   endtask

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------
   initial
   begin
      lfsr = 32'hd08dcb99;
      hang_trigger = 1'b0;
      {ex1_fra, ex1_frb, ex1_frc, ex1_frs} = '0;
      {issue_frb, issue_frc, issue_tid} = '0;
      quiet_checks();
      rst_n = 1'b0;
      repeat (4) @(negedge nclk);
      rst_n = 1'b1;

      start_test();
      drive_idle(IDLE_LEN);
      while (hold_all)
         @(negedge nclk);
      end_test("idle");

      run_sequence("correctable", 1'b0, 1'b1, 1'b0, 1, 0);
      run_sequence("fixed_itself", 1'b0, 1'b0, 1'b0, 1, 0);
      run_sequence("uncorrectable", 1'b0, 1'b1, 1'b1, 0, 1);

      start_test();
      inject_error(1'b0, 1'b0, 1'b0);
      repeat (SUP_LEN / 2) @(negedge nclk);
      inject_error(1'b0, 1'b1, 1'b1);
      repeat (SUP_LEN / 2) @(negedge nclk);
      expect_count("hold_all or sm_running cycles", busy_seen, 0);
      end_test("suppression");

      run_sequence("store", 1'b1, 1'b0, 1'b0, 1, 0);

      $display("%0d tests, %0d failed, %0d errors", tests, bad_tests, errors + uut.chk.fails);
      if (bad_tests == 0 && errors + uut.chk.fails == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
hw/fpr_perr_pkg.sv
hw/fpr_perr_if.sv
hw/perr_detect.sv
hw/perr_recovery_seq.sv
hw/rf_read_arb.sv
hw/fpr_perr_recovery.sv
testbench/fpr_perr_chk.sv
testbench/tb_fpr_perr_recovery.sv

/* Bender.yml */
package:
  name: fpr_perr_recovery

sources:
  - include_dirs:
      - include
    files:
      - hw/fpr_perr_pkg.sv
      - hw/fpr_perr_if.sv
      - hw/perr_detect.sv
      - hw/perr_recovery_seq.sv
      - hw/rf_read_arb.sv
      - hw/fpr_perr_recovery.sv
  - target: test
    files:
      - testbench/fpr_perr_chk.sv
      - testbench/tb_fpr_perr_recovery.sv
